// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_cpu -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_cpu)"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf obj_dir

// ==== compile.f ====
+incdir+test
hw/cpu_pkg.sv
hw/program_ram.sv
hw/page_mmu.sv
hw/register_bank.sv
hw/instr_sequencer.sv
hw/cpu_top.sv
test/tb_cpu.sv

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

  localparam int word_w      = 16;
  localparam int phys_addr_w = 10;  // 1024-word RAM
  localparam int page_bits   = 6;   // 64 words per page
  localparam int num_pages   = 16;
  localparam int page_idx_w  = 4;
  localparam int lpage_w     = word_w - page_bits;  // logical page number width
  localparam int num_regs    = 32;
  localparam int reg_idx_w   = 5;

  // opcodes carried in the upper byte of the head word
  localparam logic [7:0] op_jmp       = 8'd1;
  localparam logic [7:0] op_ram2reg   = 8'd2;
  localparam logic [7:0] op_reg2ram   = 8'd3;
  localparam logic [7:0] op_num2reg   = 8'd4;
  localparam logic [7:0] op_reg_plus  = 8'd5;
  localparam logic [7:0] op_reg_minus = 8'd6;
  localparam logic [7:0] op_exit      = 8'd17;

  // first word of an instruction
  typedef struct packed {
    logic [7:0] opcode;
    logic [7:0] reg_num;
  } instr_head_t;

  // a RAM word seen as an instruction head or as plain data
  typedef union packed {
    instr_head_t             head;
    logic [word_w-1:0]       raw;
  } ram_word_u;

  typedef struct packed {
    logic                    en;
    logic [phys_addr_w-1:0]  addr;
    logic [word_w-1:0]       data;
  } ram_wr_t;

  typedef enum logic [1:0] {
    alu_set,  // reg = imm
    alu_add,  // reg = reg + imm
    alu_sub   // reg = reg - imm
  } alu_op_t;

endpackage

// ==== hw/cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top (
  input  logic                             clka,
  input  logic                             rst,
  input  logic                             run,
  input  cpu_pkg::ram_wr_t                 host_wr,
  input  logic [cpu_pkg::phys_addr_w-1:0]  host_raddr,
  output logic [cpu_pkg::word_w-1:0]       rdata,
  output logic                             halted
);
  import cpu_pkg::*;

  logic                    xlate_start;
  logic [word_w-1:0]       xlate_addr;
  logic                    xlate_done;
  logic [phys_addr_w-1:0]  phys_addr;
  logic [phys_addr_w-1:0]  rd_addr;
  ram_wr_t                 core_wr;
  logic [reg_idx_w-1:0]    reg_idx;
  alu_op_t                 alu_op;
  logic [word_w-1:0]       imm;
  logic                    wr_en;
  logic                    load_en;
  logic [word_w-1:0]       load_data;
  logic [word_w-1:0]       reg_val;

  program_ram i_program_ram (
    .clka       (clka),
    .run        (run),
    .host_wr    (host_wr),
    .host_raddr (host_raddr),
    .core_wr    (core_wr),
    .rd_addr    (rd_addr),
    .rdata      (rdata)
  );

  instr_sequencer i_instr_sequencer (
    .clka, .rst, .run,
    .xlate_start, .xlate_addr, .xlate_done, .phys_addr,
    .rd_addr,
    .rdata      (rdata),      // same word, decoded through the union
    .core_wr,
    .reg_idx, .alu_op, .imm, .wr_en, .load_en, .load_data, .reg_val,
    .halted
  );

  page_mmu i_page_mmu (
    .clka, .rst, .run,
    .xlate_start, .xlate_addr, .xlate_done, .phys_addr
  );

  register_bank i_register_bank (
    .clka, .rst,
    .reg_idx, .alu_op, .imm, .wr_en, .load_en, .load_data, .reg_val
  );

endmodule

// ==== hw/instr_sequencer.sv ====
`timescale 1ns/100ps

module instr_sequencer (
  input  logic                             clka,
  input  logic                             rst,
  input  logic                             run,
  output logic                             xlate_start,
  output logic [cpu_pkg::word_w-1:0]       xlate_addr,
  input  logic                             xlate_done,
  input  logic [cpu_pkg::phys_addr_w-1:0]  phys_addr,
  output logic [cpu_pkg::phys_addr_w-1:0]  rd_addr,
  input  cpu_pkg::ram_word_u               rdata,
  output cpu_pkg::ram_wr_t                 core_wr,
  output logic [cpu_pkg::reg_idx_w-1:0]    reg_idx,
  output cpu_pkg::alu_op_t                 alu_op,
  output logic [cpu_pkg::word_w-1:0]       imm,
  output logic                             wr_en,
  output logic                             load_en,
  output logic [cpu_pkg::word_w-1:0]       load_data,
  input  logic [cpu_pkg::word_w-1:0]       reg_val,
  output logic                             halted
);
  import cpu_pkg::*;

  typedef enum logic [3:0] {
    s_head_x,     // start translation of pc
    s_head_wait,
    s_head_rd,    // head word on rdata
    s_op_wait,
    s_op_rd,      // operand word on rdata
    s_decode,
    s_mem_wait,   // data address translation for load or store
    s_load_rd,
    s_halt
  } seq_state_t;

  seq_state_t         state;
  logic [word_w-1:0]  pc;
  logic [word_w-1:0]  operand;
  instr_head_t        head;
  logic               xlate_busy;  // a translation is outstanding

  // the MMU holds phys_addr after done, so the RAM reads it directly
  assign rd_addr = phys_addr;
  assign reg_idx = head.reg_num[reg_idx_w-1:0];

  always_comb begin
    core_wr.en   = (state == s_mem_wait) && xlate_done && (head.opcode == op_reg2ram);
    core_wr.addr = phys_addr;
    core_wr.data = reg_val;
  end

  always_ff @(posedge clka) begin
    if (!rst || !run) begin
      state       <= s_head_x;
      pc          <= '0;
      xlate_start <= 1'b0;
      xlate_busy  <= 1'b0;
      wr_en       <= 1'b0;
      load_en     <= 1'b0;
      halted      <= 1'b0;
    end else begin
      xlate_start <= 1'b0;  // strobes last one cycle
      wr_en       <= 1'b0;
      load_en     <= 1'b0;
      if (xlate_start) begin
        xlate_busy <= 1'b1;
      end else if (xlate_done) begin
        xlate_busy <= 1'b0;
      end

      case (state)
        s_head_x: begin
          xlate_start <= 1'b1;
          xlate_addr  <= pc;
          state       <= s_head_wait;
        end
        s_head_wait: if (xlate_done) state <= s_head_rd;
        s_head_rd: begin
          head        <= rdata.head;
          xlate_start <= 1'b1;
          xlate_addr  <= pc + 16'd1;  // operand word
          state       <= s_op_wait;
        end
        s_op_wait: if (xlate_done) state <= s_op_rd;
        s_op_rd: begin
          operand <= rdata.raw;
          state   <= s_decode;
        end
        s_decode: begin
          pc    <= pc + 16'd2;
          state <= s_head_x;
          case (head.opcode)
            op_jmp: pc <= operand;
            op_ram2reg, op_reg2ram: begin
              xlate_start <= 1'b1;
              xlate_addr  <= operand;
              state       <= s_mem_wait;
            end
            op_num2reg: begin
              wr_en  <= 1'b1;
              alu_op <= alu_set;
              imm    <= operand;
            end
            op_reg_plus: begin
              wr_en  <= 1'b1;
              alu_op <= alu_add;
              imm    <= operand;
            end
            op_reg_minus: begin
              wr_en  <= 1'b1;
              alu_op <= alu_sub;
              imm    <= operand;
            end
            op_exit: begin
              halted <= 1'b1;
              state  <= s_halt;
            end
            default: ;  // unknown opcode, just step over it
          endcase
        end
        s_mem_wait: begin
          if (xlate_done) begin
            state <= (head.opcode == op_ram2reg) ? s_load_rd : s_head_x;
          end
        end
        s_load_rd: begin
          load_en   <= 1'b1;
          load_data <= rdata.raw;
          state     <= s_head_x;
        end
        s_halt:  state <= s_halt;  // wait for run to drop
        default: state <= s_head_x;
      endcase
    end
  end

  a_one_xlate: assert property (@(posedge clka) disable iff (!rst)
    xlate_start |-> !xlate_busy)
    else $error("translation requested while another is outstanding");

  // host may only write once the core has stopped
  a_no_core_wr_stopped: assert property (@(posedge clka) disable iff (!rst)
    !run |-> !core_wr.en)
    else $error("core write while run is low");

endmodule

// ==== hw/page_mmu.sv ====
`timescale 1ns/100ps

module page_mmu (
  input  logic                             clka,
  input  logic                             rst,
  input  logic                             run,
  input  logic                             xlate_start,
  input  logic [cpu_pkg::word_w-1:0]       xlate_addr,
  output logic                             xlate_done,
  output logic [cpu_pkg::phys_addr_w-1:0]  phys_addr
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {
    mmu_idle,
    mmu_walk,  // following the chain from page 0
    mmu_scan   // looking for a free page
  } mmu_state_t;

  mmu_state_t             state;
  logic [page_idx_w-1:0]  next_tbl  [num_pages];  // 0 marks the chain tail
  logic [lpage_w-1:0]     lpage_tbl [num_pages];
  logic [num_pages-1:0]   valid;
  logic [page_idx_w-1:0]  free_ptr;
  logic [page_idx_w-1:0]  cur_page;   // walk position, then scan position
  logic [page_idx_w-1:0]  tail_page;
  logic [lpage_w-1:0]     last_lpage;
  logic [page_idx_w-1:0]  last_ppage;
  logic [lpage_w-1:0]     req_lpage;
  logic [page_bits-1:0]   req_off;

  // xlate_addr is held until done
  assign req_lpage = xlate_addr[word_w-1:page_bits];
  assign req_off   = xlate_addr[page_bits-1:0];

  always_ff @(posedge clka) begin
    if (!rst || !run) begin
      state        <= mmu_idle;
      xlate_done   <= 1'b0;
      valid        <= num_pages'(1);  // page 0 holds logical page 0
      free_ptr     <= page_idx_w'(1);
      cur_page     <= '0;
      tail_page    <= '0;
      last_lpage   <= '0;
      last_ppage   <= '0;
      next_tbl[0]  <= '0;
      lpage_tbl[0] <= '0;
    end else begin
      xlate_done <= 1'b0;
      case (state)
        mmu_idle: begin
          if (xlate_start) begin
            if (req_lpage == last_lpage) begin
              xlate_done <= 1'b1;  // same page as last time
              phys_addr  <= {last_ppage, req_off};
            end else begin
              cur_page <= '0;
              state    <= mmu_walk;
            end
          end
        end
        mmu_walk: begin
          if (lpage_tbl[cur_page] == req_lpage) begin
            xlate_done <= 1'b1;
            phys_addr  <= {cur_page, req_off};
            last_lpage <= req_lpage;
            last_ppage <= cur_page;
            state      <= mmu_idle;
          end else if (next_tbl[cur_page] == '0) begin
            tail_page <= cur_page;
            cur_page  <= free_ptr;
            state     <= mmu_scan;
          end else begin
            cur_page <= next_tbl[cur_page];
          end
        end
        mmu_scan: begin
          if (!valid[cur_page]) begin
            valid[cur_page]     <= 1'b1;  // claim and append to tail
            lpage_tbl[cur_page] <= req_lpage;
            next_tbl[cur_page]  <= '0;
            next_tbl[tail_page] <= cur_page;
            free_ptr            <= cur_page + page_idx_w'(1);
            xlate_done          <= 1'b1;
            phys_addr           <= {cur_page, req_off};
            last_lpage          <= req_lpage;
            last_ppage          <= cur_page;
            state               <= mmu_idle;
          end else begin
            cur_page <= cur_page + page_idx_w'(1);
          end
        end
        default: state <= mmu_idle;
      endcase
    end
  end

  // out of physical pages
  a_scan_in_range: assert property (@(posedge clka) disable iff (!rst || !run)
    (state == mmu_scan) && valid[cur_page] |-> cur_page != page_idx_w'(num_pages - 1))
    else $error("page scan ran past the last physical page");

endmodule

// ==== hw/program_ram.sv ====
`timescale 1ns/100ps

module program_ram (
  input  logic                             clka,
  input  logic                             run,
  input  cpu_pkg::ram_wr_t                 host_wr,
  input  logic [cpu_pkg::phys_addr_w-1:0]  host_raddr,
  input  cpu_pkg::ram_wr_t                 core_wr,
  input  logic [cpu_pkg::phys_addr_w-1:0]  rd_addr,
  output logic [cpu_pkg::word_w-1:0]       rdata
);
  import cpu_pkg::*;

  logic [word_w-1:0]       mem [2**phys_addr_w];
  ram_wr_t                 wr;
  logic [phys_addr_w-1:0]  raddr;

  // host owns both ports while the core is stopped
  assign wr    = run ? core_wr : host_wr;
  assign raddr = run ? rd_addr : host_raddr;

  always_ff @(posedge clka) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
    rdata <= mem[raddr];  // one cycle read latency
  end

endmodule

// ==== hw/register_bank.sv ====
`timescale 1ns/100ps

module register_bank (
  input  logic                           clka,
  input  logic                           rst,
  input  logic [cpu_pkg::reg_idx_w-1:0]  reg_idx,
  input  cpu_pkg::alu_op_t               alu_op,
  input  logic [cpu_pkg::word_w-1:0]     imm,
  input  logic                           wr_en,
  input  logic                           load_en,
  input  logic [cpu_pkg::word_w-1:0]     load_data,
  output logic [cpu_pkg::word_w-1:0]     reg_val
);
  import cpu_pkg::*;

  logic [word_w-1:0] regs [num_regs];

  assign reg_val = regs[reg_idx];  // combinational read

  always_ff @(posedge clka) begin
    if (!rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (load_en) begin
      regs[reg_idx] <= load_data;  // word from RAM
    end else if (wr_en) begin
      case (alu_op)
        alu_set: regs[reg_idx] <= imm;
        alu_add: regs[reg_idx] <= regs[reg_idx] + imm;  // wraps at 16 bits
        alu_sub: regs[reg_idx] <= regs[reg_idx] - imm;
        default: ;
      endcase
    end
  end

endmodule

// ==== test/tb_tasks.svh ====
`ifndef tb_tasks_svh
`define tb_tasks_svh

  task automatic check_eq(input string name, input logic [word_w-1:0] expected,
                          input logic [word_w-1:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // called on a falling edge with run low
  task automatic host_write(input logic [phys_addr_w-1:0] addr,
                            input logic [word_w-1:0] data);
    host_wr.en   = 1'b1;
    host_wr.addr = addr;
    host_wr.data = data;
    @(negedge clka);
    host_wr.en = 1'b0;
  endtask

  task automatic host_read(input logic [phys_addr_w-1:0] addr,
                           output logic [word_w-1:0] data);
    host_raddr = addr;
    @(negedge clka);
    data = rdata;  // registered read, one cycle
  endtask

  task automatic check_ram(input string name, input logic [phys_addr_w-1:0] addr,
                           input logic [word_w-1:0] expected);
    logic [word_w-1:0] actual;
    host_read(addr, actual);
    check_eq(name, expected, actual);
  endtask

  task automatic load_program();
    foreach (prog[i]) begin
      host_write(phys_addr_w'(i), prog[i]);
    end
    prog.delete();
  endtask

  task automatic arith_and_store();
    logic [word_w-1:0] a;
    logic [word_w-1:0] b;
    logic [word_w-1:0] c;
    logic [word_w-1:0] model;
    a     = word_w'($urandom);
    b     = word_w'($urandom);
    c     = word_w'($urandom);
    model = a + b;      // wraps at 16 bits
    model = model - c;
    add_instr(op_num2reg, 8'd7, a);
    add_instr(op_reg_plus, 8'd7, b);
    add_instr(op_reg_minus, 8'd7, c);
    add_instr(op_reg2ram, 8'd7, 16'd40);  // logical page 0 is physical page 0
    add_instr(op_exit, 8'd0, 16'd0);
    start_program("arith");
    stop_core();
    check_ram("arith word 40", 10'd40, model);
  endtask

  task automatic page_allocation();
    host_write(10'd72, 16'hdead);
    host_write(10'd134, 16'hdead);
    host_write(10'd82, 16'hdead);
    add_instr(op_num2reg, 8'd1, 16'h1111);
    add_instr(op_reg2ram, 8'd1, 16'd200);  // logical page 3 takes physical page 1
    add_instr(op_num2reg, 8'd2, 16'h2222);
    add_instr(op_reg2ram, 8'd2, 16'd70);   // logical page 1 takes physical page 2
    add_instr(op_num2reg, 8'd3, 16'h3333);
    add_instr(op_reg2ram, 8'd3, 16'd210);  // page 3 already mapped
    add_instr(op_exit, 8'd0, 16'd0);
    start_program("page_alloc");
    stop_core();
    check_ram("page_alloc logical 200", 10'd72, 16'h1111);
    check_ram("page_alloc logical 70", 10'd134, 16'h2222);
    check_ram("page_alloc logical 210", 10'd82, 16'h3333);
  endtask

  task automatic store_load_round_trip();
    logic [word_w-1:0] v;
    v = word_w'($urandom);
    add_instr(op_num2reg, 8'd10, v);
    add_instr(op_reg2ram, 8'd10, 16'd300);  // page 4 offset 44 -> 64 + 44
    add_instr(op_ram2reg, 8'd11, 16'd300);
    add_instr(op_reg_plus, 8'd11, 16'd1);
    add_instr(op_reg2ram, 8'd11, 16'd301);
    add_instr(op_exit, 8'd0, 16'd0);
    start_program("round_trip");
    stop_core();
    check_ram("round_trip logical 300", 10'd108, v);
    check_ram("round_trip logical 301", 10'd109, v + 16'd1);
  endtask

  task automatic jump_skips_load();
    logic [word_w-1:0] v1;
    logic [word_w-1:0] v2;
    v1 = word_w'($urandom);
    v2 = v1 ^ 16'h5a5a;  // always differs from v1
    host_write(10'd50, ~v1);
    add_instr(op_num2reg, 8'd3, v1);
    add_instr(op_jmp, 8'd0, 16'd6);        // over the next instruction
    add_instr(op_num2reg, 8'd3, v2);
    add_instr(op_reg2ram, 8'd3, 16'd50);
    add_instr(op_exit, 8'd0, 16'd0);
    start_program("jump");
    stop_core();
    check_ram("jump word 50", 10'd50, v1);
  endtask

  task automatic halt_and_unknown_op();
    logic [word_w-1:0] v;
    v = word_w'($urandom);
    host_write(10'd44, ~v);
    host_write(10'd46, 16'hbeef);
    add_instr(op_num2reg, 8'd4, v);
    add_instr(8'h09, 8'd4, 16'hffff);      // not a known opcode
    add_instr(op_reg2ram, 8'd4, 16'd44);
    add_instr(op_exit, 8'd0, 16'd0);
    add_instr(op_reg2ram, 8'd4, 16'd46);   // past exit
    start_program("halt");
    repeat (20) begin
      @(negedge clka);
      check_eq("halt halted held", word_w'(1), word_w'(halted));
    end
    stop_core();
    check_eq("halt halted after run falls", word_w'(0), word_w'(halted));
    check_ram("halt word 44", 10'd44, v);
    check_ram("halt word 46", 10'd46, 16'hbeef);
  endtask

`endif

// ==== test/tb_cpu.sv ====
`timescale 1ns/100ps

module tb_cpu;
  import cpu_pkg::*;

  // five programs of 5 to 7 instructions, under 100 cycles each with walks,
  // plus host loads, reads and resets; the limit leaves a wide margin
  localparam int max_cycles = 20000;

  logic                    clka;
  logic                    rst;
  logic                    run;
  ram_wr_t                 host_wr;
  logic [phys_addr_w-1:0]  host_raddr;
  logic [word_w-1:0]       rdata;
  logic                    halted;

  int                      error_count = 0;
  int                      check_count = 0;
  int                      cycle_count = 0;
  logic [word_w-1:0]       prog [$];  // program image, loaded from physical word 0

  cpu_top i_cpu_top (
    .clka       (clka),
    .rst        (rst),
    .run        (run),
    .host_wr    (host_wr),
    .host_raddr (host_raddr),
    .rdata      (rdata),
    .halted     (halted)
  );

  initial clka = 1'b0;
  always #50 clka = ~clka;  // 100 ns period

  // watchdog
  always @(posedge clka) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the run hung for %0d cycles before the tests finished",
               cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  `include "tb_tasks.svh"

  task automatic reset_dut();
    @(negedge clka);
    rst = 1'b0;
    repeat (10) @(negedge clka);
    rst = 1'b1;  // released on a falling edge
  endtask

  task automatic add_instr(input logic [7:0] opcode, input logic [7:0] reg_num,
                           input logic [word_w-1:0] operand);
    instr_head_t head;
    head.opcode  = opcode;
    head.reg_num = reg_num;
    prog.push_back(head);
    prog.push_back(operand);
  endtask

  // load, reset, then run until exit
  task automatic start_program(input string name);
    load_program();
    reset_dut();
    check_eq({name, " halted after reset"}, word_w'(0), word_w'(halted));
    run = 1'b1;
    do begin
      @(negedge clka);
    end while (!halted);
  endtask

  task automatic stop_core();
    run = 1'b0;  // RAM goes back to the host
    @(negedge clka);
  endtask

  initial begin
    rst        = 1'b0;
    run        = 1'b0;
    host_wr    = '0;
    host_raddr = '0;
    void'($urandom(32'h45e0358b));  // immediates only

    reset_dut();
    arith_and_store();
    page_allocation();
    store_load_round_trip();
    jump_skips_load();
    halt_and_unknown_op();

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
